/* source/mpu_macros.svh */
// Sizing macros for the thread-program store
// Memory depth, thread queue depth, ID and word widths

`ifndef MPU_MACROS_SVH
`define MPU_MACROS_SVH

////////////////////
// Instruction memory

// Words in the circular instruction memory, power of two
`define MPU_THREAD_MEM_SIZE 64

// Word width on the store and dispatch paths
`define MPU_INSTR_WIDTH 32

////////////////////
// Thread bookkeeping

// Depth of the thread-ID queue, power of two
`define MPU_NUM_THREAD_ENTRY 8

// Thread ID bits, map table has 2**width entries
`define MPU_ID_WIDTH 4

`endif

/* source/mpu_pkg.sv */
// Memory-side types of the thread-program store
// Thread IDs, sizes, memory indices and store sequencer states

`default_nettype none

`include "mpu_macros.svh"

package mpu_pkg;

	// Thread identifier
	typedef logic [`MPU_ID_WIDTH-1:0] id_t;

	// Length or used size, one extra bit to hold the full memory size
	typedef logic [$clog2(`MPU_THREAD_MEM_SIZE):0] mpu_address_t;

	// Index into the instruction memory, wraps at the memory size
	typedef logic [$clog2(`MPU_THREAD_MEM_SIZE)-1:0] mem_index_t;

	// Store sequencer
	typedef enum logic [2:0] {
		IDLE,   // Waiting for a host request
		CHECK,  // Length word, fit test
		RCVID,  // Thread-ID word
		LOOKUP, // Map entry write
		STORE   // Instruction words
	} store_state_t;

endpackage

`default_nettype wire

/* source/isa_pkg.sv */
// Instruction word type and the host store-word union

`default_nettype none

`include "mpu_macros.svh"

package isa_pkg;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  dst;
		logic [4:0]  src1;
		logic [4:0]  src2;
		logic [10:0] imm;
	} instr_t;

	// First word of a program
	typedef struct packed {
		logic [`MPU_INSTR_WIDTH-$bits(mpu_pkg::mpu_address_t)-1:0] pad;
		mpu_pkg::mpu_address_t length;
	} length_hdr_t;

	// Second word of a program
	typedef struct packed {
		logic [`MPU_INSTR_WIDTH-$bits(mpu_pkg::id_t)-1:0] pad;
		mpu_pkg::id_t id;
	} id_hdr_t;

	// Host word, meaning depends on the store sequencer state
	typedef union packed {
		instr_t      instr;
		length_hdr_t length_hdr;
		id_hdr_t     id_hdr;
	} store_word_u;

endpackage

`default_nettype wire

/* source/ring_buff_ctrl.sv */
// Ring buffer pointer control with full and empty flags

`default_nettype none

module ring_buff_ctrl #(
	parameter int NUM_ENTRY = 8 // Power of two
) (
	input  wire                          clock,
	input  wire                          reset,
	input  wire                          we,
	input  wire                          re,
	output logic [$clog2(NUM_ENTRY)-1:0] waddr,
	output logic [$clog2(NUM_ENTRY)-1:0] raddr,
	output logic                         full,
	output logic                         empty
);

	localparam int WIDTH = $clog2(NUM_ENTRY);

	logic [WIDTH:0] count; // Occupancy, reaches NUM_ENTRY
	logic           do_write;
	logic           do_read;

	// Overflow and underflow requests are dropped
	assign do_write = we && !full;
	assign do_read  = re && !empty;

	assign full  = (count == NUM_ENTRY);
	assign empty = (count == '0);

	// Pointers wrap on their own width
	always_ff @(posedge clock) begin
		if (reset) begin
			waddr <= '0;
			raddr <= '0;
		end else begin
			if (do_write) begin
				waddr <= waddr + 1'b1;
			end
			if (do_read) begin
				raddr <= raddr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (do_write && !do_read) begin
			count <= count + 1'b1;
		end else if (do_read && !do_write) begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/thread_mem.sv */
// Thread memory: store sequencer, instruction memory, thread-ID queue
// and the synchronous load port for the dispatcher

`default_nettype none

`include "mpu_macros.svh"

module thread_mem (
	input  wire                         clock,
	input  wire                         reset,
	input  wire                         store_req,
	input  wire isa_pkg::store_word_u   store_word,
	output logic                        store_accept,
	output logic                        store_wait,   // Length word does not fit yet
	input  wire mpu_pkg::mpu_address_t  used_size,
	output logic                        map_req,
	output mpu_pkg::id_t                map_id,
	output mpu_pkg::mpu_address_t       map_length,
	input  wire                         map_ack,
	output logic                        thread_ready,
	output mpu_pkg::id_t                thread_id,
	input  wire                         thread_pop,
	input  wire                         load_req,
	input  wire mpu_pkg::mem_index_t    load_address,
	output isa_pkg::instr_t             load_instr
);

	localparam int QUEUE_WIDTH = $clog2(`MPU_NUM_THREAD_ENTRY);

	mpu_pkg::store_state_t                  state;
	mpu_pkg::store_state_t                  next_state;
	mpu_pkg::mpu_address_t                  remain;        // Words left in this program
	mpu_pkg::mem_index_t                    store_address;
	mpu_pkg::id_t                           store_id;
	logic [$bits(mpu_pkg::mpu_address_t):0] need_size;
	logic                                   fits;
	logic                                   store_done;    // Last instruction accepted

	logic [QUEUE_WIDTH-1:0] waddr;
	logic [QUEUE_WIDTH-1:0] raddr;
	logic                   queue_full;
	logic                   queue_empty;

	mpu_pkg::id_t    thread_ids [`MPU_NUM_THREAD_ENTRY];
	isa_pkg::instr_t instr_mem  [`MPU_THREAD_MEM_SIZE];

	////////////////////
	// Store sequencer

	// Extra bit so the sum cannot wrap
	assign need_size = {1'b0, used_size} + {1'b0, store_word.length_hdr.length};
	assign fits      = (need_size <= `MPU_THREAD_MEM_SIZE) && !queue_full;

	always_comb begin
		case (state)
			mpu_pkg::CHECK: store_accept = store_req && fits;
			mpu_pkg::RCVID: store_accept = store_req;
			mpu_pkg::STORE: store_accept = store_req;
			default:        store_accept = 1'b0;
		endcase
	end

	assign store_wait = (state == mpu_pkg::CHECK) && store_req && !fits;
	assign store_done = (state == mpu_pkg::STORE) && store_accept && (remain == 1);

	always_comb begin
		next_state = state;
		case (state)
			mpu_pkg::IDLE: begin
				if (store_req) begin
					next_state = mpu_pkg::CHECK;
				end
			end
			mpu_pkg::CHECK: begin
				if (store_accept) begin
					next_state = mpu_pkg::RCVID;
				end
			end
			mpu_pkg::RCVID: begin
				if (store_accept) begin
					next_state = mpu_pkg::LOOKUP;
				end
			end
			mpu_pkg::LOOKUP: begin
				if (map_ack) begin
					next_state = mpu_pkg::STORE;
				end
			end
			mpu_pkg::STORE: begin
				if (store_accept && remain == 1) begin // Last instruction
					next_state = mpu_pkg::IDLE;
				end
			end
			default: next_state = mpu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= mpu_pkg::IDLE;
			remain        <= '0;
			store_address <= '0;
		end else begin
			state <= next_state;
			if (state == mpu_pkg::CHECK && store_accept) begin
				remain <= store_word.length_hdr.length;
			end else if (state == mpu_pkg::STORE && store_accept) begin
				remain        <= remain - 1'b1;
				store_address <= store_address + 1'b1; // Wraps with the map base
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == mpu_pkg::RCVID && store_accept) begin
			store_id <= store_word.id_hdr.id;
		end
	end

	// Map entry request, length still intact until STORE
	assign map_req    = (state == mpu_pkg::LOOKUP);
	assign map_id     = store_id;
	assign map_length = remain;

	////////////////////
	// Instruction memory

	always_ff @(posedge clock) begin
		if (state == mpu_pkg::STORE && store_accept) begin
			instr_mem[store_address] <= store_word.instr;
		end
	end

	always_ff @(posedge clock) begin
		if (load_req) begin
			load_instr <= instr_mem[load_address];
		end
	end

	////////////////////
	// Thread-ID queue

	ring_buff_ctrl #(
		.NUM_ENTRY (`MPU_NUM_THREAD_ENTRY)
	) id_queue (
		.clock (clock),
		.reset (reset),
		.we    (store_done), // Push once the whole program is in memory
		.re    (thread_pop),
		.waddr (waddr),
		.raddr (raddr),
		.full  (queue_full),
		.empty (queue_empty)
	);

	always_ff @(posedge clock) begin
		if (store_done) begin
			thread_ids[waddr] <= store_id;
		end
	end

	assign thread_ready = !queue_empty;
	assign thread_id    = thread_ids[raddr];

endmodule

`default_nettype wire

/* source/map_manager.sv */
// Map manager: base and length per thread ID, write base
// and used-size accounting

`default_nettype none

`include "mpu_macros.svh"

module map_manager (
	input  wire                         clock,
	input  wire                         reset,
	input  wire                         map_req,
	input  wire mpu_pkg::id_t           map_id,
	input  wire mpu_pkg::mpu_address_t  map_length,
	output logic                        map_ack,
	input  wire mpu_pkg::id_t           lookup_id,
	output mpu_pkg::mem_index_t         lookup_base,
	output mpu_pkg::mpu_address_t       lookup_length,
	input  wire                         thread_release,
	input  wire mpu_pkg::mpu_address_t  release_length,
	output mpu_pkg::mpu_address_t       used_size
);

	localparam int NUM_ID = 1 << `MPU_ID_WIDTH;

	mpu_pkg::mem_index_t   base_table   [NUM_ID];
	mpu_pkg::mpu_address_t length_table [NUM_ID];
	mpu_pkg::mem_index_t   write_base;  // Sum of stored lengths mod memory size
	logic                  table_write;
	mpu_pkg::mpu_address_t add_size;
	mpu_pkg::mpu_address_t sub_size;

	////////////////////
	// Entry write

	// First cycle of a request only
	assign table_write = map_req && !map_ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			map_ack <= 1'b0;
		end else begin
			map_ack <= table_write;
		end
	end

	always_ff @(posedge clock) begin
		if (table_write) begin
			base_table[map_id]   <= write_base;
			length_table[map_id] <= map_length;
		end
	end

	// Low bits only, full-size length leaves the base in place
	always_ff @(posedge clock) begin
		if (reset) begin
			write_base <= '0;
		end else if (table_write) begin
			write_base <= write_base + mpu_pkg::mem_index_t'(map_length);
		end
	end

	// Dispatcher side
	assign lookup_base   = base_table[lookup_id];
	assign lookup_length = length_table[lookup_id];

	////////////////////
	// Used size

	assign add_size = table_write ? map_length : '0;
	assign sub_size = thread_release ? release_length : '0;

	// Store and release in one cycle both count
	always_ff @(posedge clock) begin
		if (reset) begin
			used_size <= '0;
		end else begin
			used_size <= used_size + add_size - sub_size;
		end
	end

endmodule

`default_nettype wire

/* source/thread_dispatch.sv */
// Thread dispatcher: pops threads in store order and streams
// their instructions out under valid/ready

`default_nettype none

module thread_dispatch (
	input  wire                         clock,
	input  wire                         reset,
	input  wire                         thread_ready,
	input  wire mpu_pkg::id_t           thread_id,
	output logic                        thread_pop,
	output mpu_pkg::id_t                lookup_id,
	input  wire mpu_pkg::mem_index_t    lookup_base,
	input  wire mpu_pkg::mpu_address_t  lookup_length,
	output logic                        load_req,
	output mpu_pkg::mem_index_t         load_address,
	input  wire isa_pkg::instr_t        load_instr,
	output logic                        instr_valid,
	output isa_pkg::instr_t             instr,
	output mpu_pkg::id_t                instr_thread_id,
	output logic                        instr_last,
	input  wire                         instr_ready,
	output logic                        thread_release,
	output mpu_pkg::mpu_address_t       release_length
);

	logic                  active;       // Thread in progress
	logic                  pend;         // Read word waiting on load_instr
	logic                  out_free;
	logic                  capture;
	logic                  fetch;
	mpu_pkg::mem_index_t   next_address;
	mpu_pkg::mpu_address_t load_left;    // Loads still to issue
	mpu_pkg::mpu_address_t capture_left; // Words still to reach the output
	mpu_pkg::mpu_address_t cur_length;
	mpu_pkg::id_t          cur_id;

	assign thread_pop = !active && thread_ready;
	assign lookup_id  = thread_id;

	assign out_free = !instr_valid || instr_ready;
	assign capture  = pend && out_free;
	// Hold off while the output is stuck and a word is already read
	assign fetch    = active && (load_left != '0) && (!pend || out_free);

	// First load goes out in the pop cycle
	assign load_req     = thread_pop || fetch;
	assign load_address = thread_pop ? lookup_base : next_address;

	assign thread_release = instr_valid && instr_ready && instr_last;
	assign release_length = cur_length;

	always_ff @(posedge clock) begin
		if (reset) begin
			active       <= 1'b0;
			pend         <= 1'b0;
			instr_valid  <= 1'b0;
			load_left    <= '0;
			capture_left <= '0;
		end else begin
			pend <= load_req || (pend && !out_free);
			if (thread_pop) begin
				active       <= 1'b1;
				load_left    <= lookup_length - 1'b1;
				capture_left <= lookup_length;
			end else begin
				if (thread_release) begin
					active <= 1'b0;
				end
				if (fetch) begin
					load_left <= load_left - 1'b1;
				end
				if (capture) begin
					capture_left <= capture_left - 1'b1;
				end
			end
			if (capture) begin
				instr_valid <= 1'b1;
			end else if (instr_ready) begin
				instr_valid <= 1'b0;
			end
		end
	end

	// Thread context and output payload
	always_ff @(posedge clock) begin
		if (thread_pop) begin
			next_address <= lookup_base + 1'b1;
			cur_length   <= lookup_length;
			cur_id       <= thread_id;
		end else if (fetch) begin
			next_address <= next_address + 1'b1; // Wraps at memory size
		end
		if (capture) begin
			instr           <= load_instr;
			instr_thread_id <= cur_id;
			instr_last      <= (capture_left == 1);
		end
	end

endmodule

`default_nettype wire

/* source/mpu_top.sv */
// Thread-program store top: thread memory, map manager, dispatcher

`default_nettype none

module mpu_top (
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        store_req,
	input  wire isa_pkg::store_word_u  store_word,
	output logic                       store_accept,
	output logic                       store_wait,
	output logic                       instr_valid,
	output isa_pkg::instr_t            instr,
	output mpu_pkg::id_t               instr_thread_id,
	output logic                       instr_last,
	input  wire                        instr_ready
);

	// Store side to map manager
	wire mpu_pkg::mpu_address_t used_size;
	wire                        map_req;
	wire mpu_pkg::id_t          map_id;
	wire mpu_pkg::mpu_address_t map_length;
	wire                        map_ack;

	// Queue and load port to dispatcher
	wire                        thread_ready;
	wire mpu_pkg::id_t          thread_id;
	wire                        thread_pop;
	wire                        load_req;
	wire mpu_pkg::mem_index_t   load_address;
	wire isa_pkg::instr_t       load_instr;

	// Dispatcher to map manager
	wire mpu_pkg::id_t          lookup_id;
	wire mpu_pkg::mem_index_t   lookup_base;
	wire mpu_pkg::mpu_address_t lookup_length;
	wire                        thread_release;
	wire mpu_pkg::mpu_address_t release_length;

	thread_mem thread_mem (
		.clock        (clock),
		.reset        (reset),
		.store_req    (store_req),
		.store_word   (store_word),
		.store_accept (store_accept),
		.store_wait   (store_wait),
		.used_size    (used_size),
		.map_req      (map_req),
		.map_id       (map_id),
		.map_length   (map_length),
		.map_ack      (map_ack),
		.thread_ready (thread_ready),
		.thread_id    (thread_id),
		.thread_pop   (thread_pop),
		.load_req     (load_req),
		.load_address (load_address),
		.load_instr   (load_instr)
	);

	map_manager map_manager (
		.clock          (clock),
		.reset          (reset),
		.map_req        (map_req),
		.map_id         (map_id),
		.map_length     (map_length),
		.map_ack        (map_ack),
		.lookup_id      (lookup_id),
		.lookup_base    (lookup_base),
		.lookup_length  (lookup_length),
		.thread_release (thread_release),
		.release_length (release_length),
		.used_size      (used_size)
	);

	thread_dispatch thread_dispatch (
		.clock           (clock),
		.reset           (reset),
		.thread_ready    (thread_ready),
		.thread_id       (thread_id),
		.thread_pop      (thread_pop),
		.lookup_id       (lookup_id),
		.lookup_base     (lookup_base),
		.lookup_length   (lookup_length),
		.load_req        (load_req),
		.load_address    (load_address),
		.load_instr      (load_instr),
		.instr_valid     (instr_valid),
		.instr           (instr),
		.instr_thread_id (instr_thread_id),
		.instr_last      (instr_last),
		.instr_ready     (instr_ready),
		.thread_release  (thread_release),
		.release_length  (release_length)
	);

endmodule

`default_nettype wire

/* tests/mpu_tb.sv */
// Testbench for the thread-program store
// Host stimulus, queue model, output assertions and closing report

`default_nettype none

`include "mpu_macros.svh"

module mpu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_SIZE    = `MPU_THREAD_MEM_SIZE;
	localparam int QUEUE_DEPTH = `MPU_NUM_THREAD_ENTRY;
	localparam int WAIT_LIMIT  = 1000; // Cycles per wait loop

	logic                 clock;
	logic                 reset;
	logic                 store_req;
	isa_pkg::store_word_u store_word;
	logic                 store_accept;
	logic                 store_wait;
	logic                 instr_valid;
	isa_pkg::instr_t      instr;
	mpu_pkg::id_t         instr_thread_id;
	logic                 instr_last;
	logic                 instr_ready;

	integer seed;
	integer gap_seed;      // Separate stream for ready gaps
	int     ready_mode;    // 0 low, 1 high, 2 random
	int     mismatches;
	int     timeouts;
	int     next_id;
	int     i;

	////////////////////
	// Reference model

	isa_pkg::instr_t exp_instr_q[$];
	mpu_pkg::id_t    exp_id_q[$];
	logic            exp_last_q[$];
	int              exp_len_q[$];   // One entry per resident thread
	logic            head_valid;
	isa_pkg::instr_t head_instr;
	mpu_pkg::id_t    head_id;
	logic            head_last;
	int              model_used;     // Stored minus completed lengths
	int              model_resident;
	logic            checking;       // Length word offered, sequencer in CHECK
	int              offer_len;
	logic            size_over;
	logic            out_accept;

	assign size_over  = (model_used + offer_len) > MEM_SIZE;
	assign out_accept = instr_valid && instr_ready;

	mpu_top DUT (
		.clock           (clock),
		.reset           (reset),
		.store_req       (store_req),
		.store_word      (store_word),
		.store_accept    (store_accept),
		.store_wait      (store_wait),
		.instr_valid     (instr_valid),
		.instr           (instr),
		.instr_thread_id (instr_thread_id),
		.instr_last      (instr_last),
		.instr_ready     (instr_ready)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Sink side, changes on the falling edge
	always @(negedge clock) begin
		case (ready_mode)
			0:       instr_ready <= 1'b0;
			1:       instr_ready <= 1'b1;
			default: instr_ready <= ($random(gap_seed) % 4) != 0;
		endcase
	end

	task automatic refresh_head();
		head_valid = (exp_instr_q.size() != 0);
		if (head_valid) begin
			head_instr = exp_instr_q[0];
			head_id    = exp_id_q[0];
			head_last  = exp_last_q[0];
		end
	endtask

	// Retire the head word on each output handshake
	always @(posedge clock) begin
		if (!reset && out_accept && head_valid) begin
			if (head_last) begin
				model_used     = model_used - exp_len_q.pop_front();
				model_resident = model_resident - 1;
			end
			void'(exp_instr_q.pop_front());
			void'(exp_id_q.pop_front());
			void'(exp_last_q.pop_front());
			refresh_head();
		end
	end

	////////////////////
	// Assertions

	reset_idle: assert property (@(posedge clock)
			$fell(reset) |-> !instr_valid && !store_accept && !store_wait)
		else begin
			mismatches++;
			$display("mismatch at %0t: handshake outputs not low after reset", $time);
		end

	out_expected: assert property (@(posedge clock) disable iff (reset)
			out_accept |-> head_valid)
		else begin
			mismatches++;
			$display("mismatch at %0t: output word with no program left in the model", $time);
		end

	out_word: assert property (@(posedge clock) disable iff (reset)
			out_accept && head_valid |-> instr == head_instr)
		else begin
			mismatches++;
			$display("mismatch at %0t: instr %h, expected %h", $time,
				$sampled(instr), $sampled(head_instr));
		end

	out_id: assert property (@(posedge clock) disable iff (reset)
			out_accept && head_valid |-> instr_thread_id == head_id)
		else begin
			mismatches++;
			$display("mismatch at %0t: thread id %0d, expected %0d", $time,
				$sampled(instr_thread_id), $sampled(head_id));
		end

	out_last: assert property (@(posedge clock) disable iff (reset)
			out_accept && head_valid |-> instr_last == head_last)
		else begin
			mismatches++;
			$display("mismatch at %0t: last flag %b, expected %b", $time,
				$sampled(instr_last), $sampled(head_last));
		end

	// Payload frozen under back-pressure
	out_hold: assert property (@(posedge clock) disable iff (reset)
			instr_valid && !instr_ready |=> instr_valid && $stable(instr)
			&& $stable(instr_thread_id) && $stable(instr_last))
		else begin
			mismatches++;
			$display("mismatch at %0t: output changed while held by back-pressure", $time);
		end

	cap_over: assert property (@(posedge clock) disable iff (reset)
			checking && size_over |-> store_wait && !store_accept)
		else begin
			mismatches++;
			$display("mismatch at %0t: length %0d with %0d used not held off", $time,
				$sampled(offer_len), $sampled(model_used));
		end

	cap_accept: assert property (@(posedge clock) disable iff (reset)
			checking && store_accept |-> !size_over && model_resident <= QUEUE_DEPTH)
		else begin
			mismatches++;
			$display("mismatch at %0t: length word accepted without room", $time);
		end

	cap_wait: assert property (@(posedge clock) disable iff (reset)
			checking && store_wait |-> !store_accept
			&& (size_over || model_resident >= QUEUE_DEPTH))
		else begin
			mismatches++;
			$display("mismatch at %0t: wait raised with room left", $time);
		end

	cap_room: assert property (@(posedge clock) disable iff (reset)
			checking && !size_over && model_resident < QUEUE_DEPTH |-> store_accept)
		else begin
			mismatches++;
			$display("mismatch at %0t: fitting length word not accepted", $time);
		end

	// Queue full with one thread in the dispatcher
	queue_stop: assert property (@(posedge clock) disable iff (reset)
			checking && model_resident > QUEUE_DEPTH |-> store_wait && !store_accept)
		else begin
			mismatches++;
			$display("mismatch at %0t: store accepted past the thread queue depth", $time);
		end

	////////////////////
	// Host side

	task automatic wait_accept(input string what, output bit ok);
		int cycles;
		cycles = 0;
		ok     = 1'b0;
		while (!ok && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			ok = store_accept;
			cycles++;
		end
		if (!ok) begin
			timeouts++;
			$display("timeout at %0t: no store_accept for the %s, sequencer in %s",
				$time, what, DUT.thread_mem.state.name());
		end
	endtask

	task automatic send_program(input int len);
		isa_pkg::instr_t words[$];
		mpu_pkg::id_t    id;
		bit              ok;
		int              n;
		int              k;
		id = mpu_pkg::id_t'(next_id);
		next_id++;
		for (k = 0; k < len; k++) begin
			words.push_back(isa_pkg::instr_t'($random(seed)));
		end
		ok = 1'b1;
		for (n = 0; n < len + 2 && ok; n++) begin
			@(negedge clock);
			store_req  = 1'b1;
			store_word = '0;
			if (n == 0) begin
				store_word.length_hdr.length = mpu_pkg::mpu_address_t'(len);
				@(posedge clock); // IDLE to CHECK, nothing taken
				@(negedge clock);
				checking  = 1'b1;
				offer_len = len;
				wait_accept("length word", ok);
				checking = 1'b0;
				if (ok) begin
					model_used     = model_used + len;
					model_resident = model_resident + 1;
					exp_len_q.push_back(len);
					for (k = 0; k < len; k++) begin
						exp_instr_q.push_back(words[k]);
						exp_id_q.push_back(id);
						exp_last_q.push_back(k == len - 1);
					end
					refresh_head();
				end
			end else if (n == 1) begin
				store_word.id_hdr.id = id;
				wait_accept("thread ID word", ok);
			end else begin
				store_word.instr = words[n-2];
				wait_accept("instruction word", ok);
			end
		end
		@(negedge clock);
		store_req = 1'b0;
	endtask

	task automatic wait_for_stall(input string what);
		int cycles;
		cycles = 0;
		while (!store_wait && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (!store_wait) begin
			timeouts++;
			$display("timeout at %0t: host never stalled on the %s", $time, what);
		end
	endtask

	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		while (model_resident != 0 && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (model_resident != 0) begin
			timeouts++;
			$display("timeout at %0t: %0d threads never came out after the %s",
				$time, model_resident, what);
		end
	endtask

	initial begin
		seed           = 8;
		gap_seed       = seed + 1;
		reset          = 1'b1;
		store_req      = 1'b0;
		store_word     = '0;
		instr_ready    = 1'b0;
		ready_mode     = 0;
		mismatches     = 0;
		timeouts       = 0;
		next_id        = 0;
		model_used     = 0;
		model_resident = 0;
		checking       = 1'b0;
		offer_len      = 0;
		refresh_head();
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(posedge clock);

		// Random programs, total well past the memory size
		ready_mode = 2;
		for (i = 0; i < 14; i++) begin
			send_program(1 + $unsigned($random(seed)) % 12);
		end
		wait_drained("random programs");

		// Third program does not fit until the first drains
		ready_mode = 0;
		fork
			begin
				send_program(30);
				send_program(30);
				send_program(20);
			end
			begin
				wait_for_stall("capacity limit");
				repeat (20) @(posedge clock);
				ready_mode = 2;
			end
		join
		wait_drained("capacity test");

		// Queue full plus one thread stuck in the dispatcher
		ready_mode = 0;
		fork
			begin
				for (i = 0; i < QUEUE_DEPTH + 2; i++) begin
					send_program(2);
				end
			end
			begin
				wait_for_stall("thread queue limit");
				repeat (20) @(posedge clock);
				ready_mode = 1;
			end
		join
		wait_drained("queue test");

		repeat (5) @(posedge clock);
		$display("Closing report: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/mpu_pkg.sv
source/isa_pkg.sv
source/ring_buff_ctrl.sv
source/thread_mem.sv
source/map_manager.sv
source/thread_dispatch.sv
source/mpu_top.sv
tests/mpu_tb.sv
